// File: burst/axi_rd_burst.sv
/*
 * AXI4 read burst splitter
 * Issues one single-word read per beat and returns it as an R beat
 */

`timescale 1ns/10ps
`include "axi2iob_defs.svh"

module axi_rd_burst
   import axi_pkg::*;
   import iob_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_i,
   input  axi_addr_t   ar_i,
   input  logic        ar_valid_i,
   output logic        ar_ready_o,
   output axi_r_t      r_o,
   output logic        r_valid_o,
   input  logic        r_ready_i,
   output iob_rd_req_t rd_req_o,
   output logic        rd_req_valid_o,
   input  logic        rd_req_ready_i,
   input  iob_rd_rsp_t rd_rsp_i,
   input  logic        rd_rsp_valid_i,
   output logic        rd_rsp_ready_o
);

   burst_state_e state_q;

   logic [`AXI2IOB_ID_W-1:0]   id_q;
   logic [`AXI2IOB_ADDR_W-1:0] addr_q;
   logic [`AXI2IOB_LEN_W-1:0]  len_q;
   logic [`AXI2IOB_SIZE_W-1:0] size_q;
   logic [`AXI2IOB_ADDR_W-1:0] ar_step;
   logic [`AXI2IOB_ADDR_W-1:0] step;

   iob_rd_req_t                req_q;
   logic [`AXI2IOB_ID_W-1:0]   r_id_q;
   logic [`AXI2IOB_DATA_W-1:0] r_data_q;
   logic                       r_last_q;
   logic                       ar_ready_q;
   logic                       req_valid_q;
   logic                       r_valid_q;

   logic ar_fire;
   logic req_fire;
   logic rsp_fire;
   logic r_fire;

   assign ar_fire  = ar_valid_i & ar_ready_q;
   assign req_fire = req_valid_q & rd_req_ready_i;
   assign rsp_fire = rd_rsp_valid_i & rd_rsp_ready_o;
   assign r_fire   = r_valid_q & r_ready_i;

   assign ar_step = {{(`AXI2IOB_ADDR_W-1){1'b0}}, 1'b1} << ar_i.size;
   assign step    = {{(`AXI2IOB_ADDR_W-1){1'b0}}, 1'b1} << size_q;

   // Only take a response while the R slot is free
   assign rd_rsp_ready_o = (state_q == BURST_DATA) & ~r_valid_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q     <= BURST_IDLE;
         ar_ready_q  <= 1'b0;
         req_valid_q <= 1'b0;
         r_valid_q   <= 1'b0;
      end else if (state_q == BURST_DATA) begin
         if (req_fire) begin
            req_valid_q <= 1'b0;
         end
         if (rsp_fire) begin
            r_valid_q <= 1'b1;
         end
         // Next read waits until the current beat leaves on R
         if (r_fire) begin
            r_valid_q <= 1'b0;
            if (r_last_q) begin
               ar_ready_q <= 1'b1;
               state_q    <= BURST_IDLE;
            end else begin
               req_valid_q <= 1'b1;
            end
         end
      end else begin
         ar_ready_q <= ~ar_fire;
         if (ar_fire) begin
            req_valid_q <= 1'b1;
            state_q     <= BURST_DATA;
         end
      end
   end

   // addr_q holds the address of the next request
   always_ff @(posedge clk_i) begin
      if (ar_fire) begin
         id_q       <= ar_i.id;
         size_q     <= ar_i.size;
         req_q.addr <= ar_i.addr;
         addr_q     <= ar_i.addr + ar_step;
      end else if (r_fire & ~r_last_q) begin
         req_q.addr <= addr_q;
         addr_q     <= addr_q + step;
      end
      if (ar_fire) begin
         len_q <= ar_i.len;
      end else if (rsp_fire) begin
         len_q <= len_q - 1'b1;
      end
      if (rsp_fire) begin
         r_id_q   <= id_q;
         r_data_q <= rd_rsp_i.data;
         r_last_q <= (len_q == '0);
      end
   end

   assign ar_ready_o     = ar_ready_q;
   assign rd_req_o       = req_q;
   assign rd_req_valid_o = req_valid_q;
   assign r_valid_o      = r_valid_q;
   assign r_o            = '{id: r_id_q, data: r_data_q, resp: 2'b00, last: r_last_q};

endmodule

// File: burst/axi_wr_burst.sv
/*
 * AXI4 write burst splitter
 * Turns one AW and its W beats into single-word writes and one B
 */

`timescale 1ns/10ps
`include "axi2iob_defs.svh"

module axi_wr_burst
   import axi_pkg::*;
   import iob_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_i,
   input  axi_addr_t   aw_i,
   input  logic        aw_valid_i,
   output logic        aw_ready_o,
   input  axi_w_t      w_i,
   input  logic        w_valid_i,
   output logic        w_ready_o,
   output axi_b_t      b_o,
   output logic        b_valid_o,
   input  logic        b_ready_i,
   output iob_wr_req_t wr_req_o,
   output logic        wr_req_valid_o,
   input  logic        wr_req_ready_i,
   input  logic        wr_done_i
);

   burst_state_e state_q;

   logic [`AXI2IOB_ID_W-1:0]   id_q;
   logic [`AXI2IOB_ADDR_W-1:0] addr_q;
   logic [`AXI2IOB_LEN_W-1:0]  len_q;
   logic [`AXI2IOB_SIZE_W-1:0] size_q;
   logic [`AXI2IOB_ADDR_W-1:0] step;

   iob_wr_req_t req_q;
   logic        last_q;
   logic        aw_ready_q;
   logic        w_ready_q;
   logic        b_valid_q;
   logic        req_valid_q;

   logic aw_fire;
   logic w_fire;
   logic b_fire;
   logic req_fire;

   assign aw_fire  = aw_valid_i & aw_ready_q;
   assign w_fire   = w_valid_i & w_ready_q;
   assign b_fire   = b_valid_q & b_ready_i;
   assign req_fire = req_valid_q & wr_req_ready_i;

   // Byte distance between beats
   assign step = {{(`AXI2IOB_ADDR_W-1){1'b0}}, 1'b1} << size_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q     <= BURST_IDLE;
         aw_ready_q  <= 1'b0;
         w_ready_q   <= 1'b0;
         b_valid_q   <= 1'b0;
         req_valid_q <= 1'b0;
      end else begin
         case (state_q)
            BURST_IDLE: begin
               aw_ready_q <= ~aw_fire;
               if (aw_fire) begin
                  w_ready_q <= 1'b1;
                  state_q   <= BURST_DATA;
               end
            end
            BURST_DATA: begin
               if (w_fire) begin
                  w_ready_q   <= 1'b0;
                  req_valid_q <= 1'b1;
                  state_q     <= BURST_RESP;
               end
            end
            BURST_RESP: begin
               if (req_fire) begin
                  req_valid_q <= 1'b0;
               end
               // Beat written or skipped
               if (wr_done_i) begin
                  if (last_q) begin
                     b_valid_q <= 1'b1;
                  end else begin
                     w_ready_q <= 1'b1;
                     state_q   <= BURST_DATA;
                  end
               end
               if (b_fire) begin
                  b_valid_q  <= 1'b0;
                  aw_ready_q <= 1'b1;
                  state_q    <= BURST_IDLE;
               end
            end
            default: state_q <= BURST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (aw_fire) begin
         id_q   <= aw_i.id;
         addr_q <= aw_i.addr;
         len_q  <= aw_i.len;
         size_q <= aw_i.size;
      end else if (w_fire) begin
         req_q.addr <= addr_q;
         req_q.data <= w_i.data;
         req_q.strb <= w_i.strb;
         last_q     <= (len_q == '0);
         addr_q     <= addr_q + step;
         len_q      <= len_q - 1'b1;
      end
   end

   assign aw_ready_o     = aw_ready_q;
   assign w_ready_o      = w_ready_q;
   assign wr_req_o       = req_q;
   assign wr_req_valid_o = req_valid_q;
   assign b_valid_o      = b_valid_q;
   // Response code is filled in at the top level
   assign b_o            = '{id: id_q, resp: 2'b00};

endmodule

// File: common/axi2iob_defs.svh
/*
 * Bus widths and response codes of the AXI4 to IOb adapter
 */

`ifndef AXI2IOB_DEFS_SVH
`define AXI2IOB_DEFS_SVH

// Native bus widths
`define AXI2IOB_ADDR_W 32
`define AXI2IOB_DATA_W 32
`define AXI2IOB_STRB_W 4

// AXI control field widths
`define AXI2IOB_ID_W   4
`define AXI2IOB_LEN_W  8
`define AXI2IOB_SIZE_W 3

// Only OKAY is ever returned
`define AXI2IOB_RESP_OKAY 2'b00

`endif

// File: common/axi_pkg.sv
/*
 * AXI4 subordinate channel payload structs
 * and the burst splitter state encoding
 */

`include "axi2iob_defs.svh"

package axi_pkg;

   // AW or AR request
   typedef struct packed {
      logic [`AXI2IOB_ID_W-1:0]   id;
      logic [`AXI2IOB_ADDR_W-1:0] addr;
      logic [`AXI2IOB_LEN_W-1:0]  len;
      logic [`AXI2IOB_SIZE_W-1:0] size;
   } axi_addr_t;

   typedef struct packed {
      logic [`AXI2IOB_DATA_W-1:0] data;
      logic [`AXI2IOB_STRB_W-1:0] strb;
      logic                       last;
   } axi_w_t;

   typedef struct packed {
      logic [`AXI2IOB_ID_W-1:0] id;
      logic [1:0]               resp;
   } axi_b_t;

   typedef struct packed {
      logic [`AXI2IOB_ID_W-1:0]   id;
      logic [`AXI2IOB_DATA_W-1:0] data;
      logic [1:0]                 resp;
      logic                       last;
   } axi_r_t;

   typedef enum logic [1:0] {
      BURST_IDLE = 2'd0,
      BURST_DATA = 2'd1,
      BURST_RESP = 2'd2
   } burst_state_e;

endpackage

// File: common/iob_pkg.sv
/*
 * Single-beat request and response structs of the native bus,
 * granted operation and bridge state encodings
 */

`include "axi2iob_defs.svh"

package iob_pkg;

   typedef struct packed {
      logic [`AXI2IOB_ADDR_W-1:0] addr;
      logic [`AXI2IOB_DATA_W-1:0] data;
      logic [`AXI2IOB_STRB_W-1:0] strb;
   } iob_wr_req_t;

   typedef struct packed {
      logic [`AXI2IOB_ADDR_W-1:0] addr;
   } iob_rd_req_t;

   typedef struct packed {
      logic [`AXI2IOB_DATA_W-1:0] data;
   } iob_rd_rsp_t;

   // A zero wstrb marks a read
   typedef struct packed {
      logic [`AXI2IOB_ADDR_W-1:0] addr;
      logic [`AXI2IOB_DATA_W-1:0] wdata;
      logic [`AXI2IOB_STRB_W-1:0] wstrb;
   } iob_req_t;

   typedef enum logic {
      IOB_OP_READ  = 1'b0,
      IOB_OP_WRITE = 1'b1
   } iob_op_e;

   typedef enum logic {
      BRIDGE_IDLE    = 1'b0,
      BRIDGE_RD_WAIT = 1'b1
   } bridge_state_e;

endpackage

// File: compile.f
+incdir+common
common/axi_pkg.sv
common/iob_pkg.sv
burst/axi_wr_burst.sv
burst/axi_rd_burst.sv
logic/iob_bridge.sv
logic/axi2iob_top.sv
verif/axi2iob_assert.sv
verif/axi2iob_tb.sv

// File: logic/axi2iob_top.sv
/*
 * AXI4 subordinate to IOb native bus adapter
 */

`timescale 1ns/10ps
`include "axi2iob_defs.svh"

module axi2iob_top
   import axi_pkg::*;
   import iob_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_i,
   input  axi_addr_t   s_aw_i,
   input  logic        s_aw_valid_i,
   output logic        s_aw_ready_o,
   input  axi_w_t      s_w_i,
   input  logic        s_w_valid_i,
   output logic        s_w_ready_o,
   output axi_b_t      s_b_o,
   output logic        s_b_valid_o,
   input  logic        s_b_ready_i,
   input  axi_addr_t   s_ar_i,
   input  logic        s_ar_valid_i,
   output logic        s_ar_ready_o,
   output axi_r_t      s_r_o,
   output logic        s_r_valid_o,
   input  logic        s_r_ready_i,
   output logic        iob_valid_o,
   output iob_req_t    iob_req_o,
   input  logic        iob_ready_i,
   input  logic        iob_rvalid_i,
   input  logic [31:0] iob_rdata_i
);

   iob_wr_req_t wr_req;
   iob_rd_req_t rd_req;
   iob_rd_rsp_t rd_rsp;
   axi_b_t      wr_b;
   axi_r_t      rd_r;
   logic        wr_req_valid, wr_req_ready, wr_done;
   logic        rd_req_valid, rd_req_ready, rd_rsp_valid, rd_rsp_ready;

   axi_wr_burst wr_burst0 (.clk_i, .arst_i, .aw_i(s_aw_i), .aw_valid_i(s_aw_valid_i),
      .aw_ready_o(s_aw_ready_o), .w_i(s_w_i), .w_valid_i(s_w_valid_i), .w_ready_o(s_w_ready_o),
      .b_o(wr_b), .b_valid_o(s_b_valid_o), .b_ready_i(s_b_ready_i), .wr_req_o(wr_req),
      .wr_req_valid_o(wr_req_valid), .wr_req_ready_i(wr_req_ready), .wr_done_i(wr_done));

   axi_rd_burst rd_burst0 (.clk_i, .arst_i, .ar_i(s_ar_i), .ar_valid_i(s_ar_valid_i),
      .ar_ready_o(s_ar_ready_o), .r_o(rd_r), .r_valid_o(s_r_valid_o), .r_ready_i(s_r_ready_i),
      .rd_req_o(rd_req), .rd_req_valid_o(rd_req_valid), .rd_req_ready_i(rd_req_ready),
      .rd_rsp_i(rd_rsp), .rd_rsp_valid_i(rd_rsp_valid), .rd_rsp_ready_o(rd_rsp_ready));

   iob_bridge bridge0 (.clk_i, .arst_i, .wr_req_i(wr_req), .wr_req_valid_i(wr_req_valid),
      .wr_req_ready_o(wr_req_ready), .wr_done_o(wr_done), .rd_req_i(rd_req),
      .rd_req_valid_i(rd_req_valid), .rd_req_ready_o(rd_req_ready), .rd_rsp_o(rd_rsp),
      .rd_rsp_valid_o(rd_rsp_valid), .rd_rsp_ready_i(rd_rsp_ready), .iob_valid_o,
      .iob_req_o, .iob_ready_i, .iob_rvalid_i, .iob_rdata_i);

   // Every access completes with OKAY
   assign s_b_o = '{id: wr_b.id, resp: `AXI2IOB_RESP_OKAY};
   assign s_r_o = '{id: rd_r.id, data: rd_r.data, resp: `AXI2IOB_RESP_OKAY, last: rd_r.last};

endmodule

// File: logic/iob_bridge.sv
/*
 * Arbiter of single-beat reads and writes onto one IOb port
 * with a held read data register
 */

`timescale 1ns/10ps

module iob_bridge
   import iob_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_i,
   input  iob_wr_req_t wr_req_i,
   input  logic        wr_req_valid_i,
   output logic        wr_req_ready_o,
   output logic        wr_done_o,
   input  iob_rd_req_t rd_req_i,
   input  logic        rd_req_valid_i,
   output logic        rd_req_ready_o,
   output iob_rd_rsp_t rd_rsp_o,
   output logic        rd_rsp_valid_o,
   input  logic        rd_rsp_ready_i,
   output logic        iob_valid_o,
   output iob_req_t    iob_req_o,
   input  logic        iob_ready_i,
   input  logic        iob_rvalid_i,
   input  logic [31:0] iob_rdata_i
);

   bridge_state_e state_q;
   iob_op_e       op;
   iob_op_e       op_q;
   iob_rd_rsp_t   rsp_q;
   logic          rsp_valid_q;
   logic          pend_q;
   logic          rd_allow;
   logic          wr_zero;

   // One read in flight, and none while the last word is unread
   assign rd_allow = (state_q == BRIDGE_IDLE) & ~rsp_valid_q;
   assign wr_zero  = ~|wr_req_i.strb;

   // A stalled request keeps its grant so the port stays stable
   always_comb begin
      if (pend_q) begin
         op = op_q;
      end else if (rd_req_valid_i & rd_allow) begin
         op = IOB_OP_READ;
      end else begin
         op = IOB_OP_WRITE;
      end
   end

   assign rd_req_ready_o = (op == IOB_OP_READ) & iob_ready_i;
   assign wr_req_ready_o = (op == IOB_OP_WRITE) & (wr_zero | iob_ready_i);
   assign wr_done_o      = wr_req_ready_o & wr_req_valid_i;

   assign iob_valid_o = (op == IOB_OP_READ) ? rd_req_valid_i : (wr_req_valid_i & ~wr_zero);

   always_comb begin
      if (op == IOB_OP_READ) begin
         iob_req_o = '{addr: rd_req_i.addr, wdata: '0, wstrb: '0};
      end else begin
         iob_req_o = '{addr: wr_req_i.addr, wdata: wr_req_i.data, wstrb: wr_req_i.strb};
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q     <= BRIDGE_IDLE;
         op_q        <= IOB_OP_WRITE;
         pend_q      <= 1'b0;
         rsp_valid_q <= 1'b0;
      end else begin
         op_q   <= op;
         pend_q <= iob_valid_o & ~iob_ready_i;
         if (rd_req_valid_i & rd_req_ready_o) begin
            state_q <= BRIDGE_RD_WAIT;
         end else if (iob_rvalid_i) begin
            state_q <= BRIDGE_IDLE;
         end
         if (iob_rvalid_i) begin
            rsp_valid_q <= 1'b1;
         end else if (rd_rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (iob_rvalid_i) begin
         rsp_q.data <= iob_rdata_i;
      end
   end

   assign rd_rsp_o       = rsp_q;
   assign rd_rsp_valid_o = rsp_valid_q;

endmodule

// File: verif/axi2iob_assert.sv
/*
 * Concurrent protocol assertions bound to the adapter top level
 */

`timescale 1ns/10ps

module axi2iob_assert
   import axi_pkg::*;
   import iob_pkg::*;
(
   input logic     clk_i,
   input logic     arst_i,
   input logic     iob_valid_i,
   input iob_req_t iob_req_i,
   input logic     iob_ready_i,
   input axi_r_t   r_i,
   input logic     r_valid_i,
   input logic     r_ready_i,
   input logic     b_valid_i,
   input logic     b_ready_i,
   input logic     wr_req_valid_i,
   input logic     rd_req_valid_i,
   input logic     rd_rsp_valid_i
);

   int unsigned fail_cnt = 0;

   // A stalled IOb request keeps its address and data
   iob_req_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      iob_valid_i && !iob_ready_i |=> iob_valid_i && $stable(iob_req_i))
   else begin
      $error("IOb request changed while stalled");
      fail_cnt++;
   end

   r_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
   else begin
      $error("R beat changed while stalled");
      fail_cnt++;
   end

   b_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      b_valid_i && !b_ready_i |=> b_valid_i)
   else begin
      $error("B valid dropped before the handshake");
      fail_cnt++;
   end

   reset_idle: assert property (@(posedge clk_i)
      arst_i |-> !(iob_valid_i || r_valid_i || b_valid_i ||
                   wr_req_valid_i || rd_req_valid_i || rd_rsp_valid_i))
   else begin
      $error("Valid signal high during reset");
      fail_cnt++;
   end

endmodule

// File: verif/axi2iob_tb.sv
/*
 * Testbench of the AXI4 to IOb adapter
 * Random bursts, IOb memory model, reference model of B and R, timeout
 */

`timescale 1ns/10ps

module axi2iob_tb
   import axi_pkg::*;
   import iob_pkg::*;
();

   localparam int NUM_PAIRS   = 16;
   localparam int NUM_OVERLAP = 4;
   // 44 bursts of up to 16 beats at 12 cycles per beat, plus reset
   localparam int MAX_CYCLES  = (2 * NUM_PAIRS + 3 * NUM_OVERLAP) * 16 * 12 + 8;

   typedef struct packed {
      logic [3:0]  id;
      logic [31:0] addr;
      logic [31:0] data;
      logic        last;
   } r_exp_t;

   logic        clk_i;
   logic        arst_i;
   axi_addr_t   s_aw_i;
   logic        s_aw_valid_i;
   logic        s_aw_ready_o;
   axi_w_t      s_w_i;
   logic        s_w_valid_i;
   logic        s_w_ready_o;
   axi_b_t      s_b_o;
   logic        s_b_valid_o;
   logic        s_b_ready_i;
   axi_addr_t   s_ar_i;
   logic        s_ar_valid_i;
   logic        s_ar_ready_o;
   axi_r_t      s_r_o;
   logic        s_r_valid_o;
   logic        s_r_ready_i;
   logic        iob_valid_o;
   iob_req_t    iob_req_o;
   logic        iob_ready_i;
   logic        iob_rvalid_i;
   logic [31:0] iob_rdata_i;

   integer      seed;
   int unsigned data_errs;
   int unsigned proto_errs;
   int unsigned cycles;
   int          w_left;
   int          rd_wait;
   logic [31:0] rd_word;

   logic [31:0] ref_mem [logic [31:0]];
   logic [31:0] iob_mem [logic [31:0]];
   bit          zero_addr [logic [31:0]];
   logic [3:0]  b_exp_q [$];
   r_exp_t      r_exp_q [$];

   logic [31:0] pair_addr [NUM_PAIRS];
   logic [7:0]  pair_len [NUM_PAIRS];
   logic [2:0]  pair_size [NUM_PAIRS];

   logic [31:0] ovl_addr [NUM_OVERLAP];
   logic [7:0]  ovl_len [NUM_OVERLAP];
   logic [2:0]  ovl_size [NUM_OVERLAP];

   always #10 clk_i = ~clk_i;

   axi2iob_top dut0 (.*);

   bind axi2iob_top axi2iob_assert assert0 (
      .clk_i, .arst_i,
      .iob_valid_i(iob_valid_o), .iob_req_i(iob_req_o), .iob_ready_i,
      .r_i(s_r_o), .r_valid_i(s_r_valid_o), .r_ready_i(s_r_ready_i),
      .b_valid_i(s_b_valid_o), .b_ready_i(s_b_ready_i),
      .wr_req_valid_i(wr_req_valid), .rd_req_valid_i(rd_req_valid),
      .rd_rsp_valid_i(rd_rsp_valid)
   );

   // Unwritten words read as a pattern of their address
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return addr ^ 32'h5ac3_0f96;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
      logic [31:0] word;
      int          b;
      word = old_word;
      for (b = 0; b < 4; b++) begin
         if (strb[b]) begin
            word[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return word;
   endfunction

   function automatic logic [31:0] ref_word(input logic [31:0] addr);
      if (ref_mem.exists(addr)) begin
         return ref_mem[addr];
      end
      return fill_word(addr);
   endfunction

   task automatic print_summary();
      $display("Errors: %0d data, %0d protocol, %0d assertion",
               data_errs, proto_errs, dut0.assert0.fail_cnt);
   endtask

   task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
                              input logic [7:0] len, input logic [2:0] size);
      logic [31:0] beat_addr;
      logic [31:0] data;
      logic [31:0] r;
      logic [3:0]  strb;
      int          i;
      zero_addr.delete();
      s_aw_i       <= '{id: id, addr: addr, len: len, size: size};
      s_aw_valid_i <= 1'b1;
      @(posedge clk_i);
      while (!s_aw_ready_o) begin
         @(posedge clk_i);
      end
      s_aw_valid_i <= 1'b0;
      b_exp_q.push_back(id);
      w_left = len + 1;
      for (i = 0; i <= len; i++) begin
         beat_addr = addr + (i << size);
         data      = $random(seed);
         r         = $random(seed);
         // About one beat in four carries no strobes
         strb = (r[5:4] == 2'b00) ? 4'h0 : r[3:0];
         if (strb == 4'h0) begin
            zero_addr[beat_addr] = 1'b1;
         end
         ref_mem[beat_addr] = merge_bytes(ref_word(beat_addr), data, strb);
         s_w_i       <= '{data: data, strb: strb, last: (i == len)};
         s_w_valid_i <= 1'b1;
         @(posedge clk_i);
         while (!s_w_ready_o) begin
            @(posedge clk_i);
         end
         w_left = w_left - 1;
      end
      s_w_valid_i <= 1'b0;
      @(posedge clk_i);
      while (!(s_b_valid_o && s_b_ready_i)) begin
         @(posedge clk_i);
      end
   endtask

   task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
                             input logic [7:0] len, input logic [2:0] size);
      logic [31:0] beat_addr;
      int          i;
      int          beats;
      for (i = 0; i <= len; i++) begin
         beat_addr = addr + (i << size);
         r_exp_q.push_back('{id: id, addr: beat_addr, data: ref_word(beat_addr),
                             last: (i == len)});
      end
      s_ar_i       <= '{id: id, addr: addr, len: len, size: size};
      s_ar_valid_i <= 1'b1;
      @(posedge clk_i);
      while (!s_ar_ready_o) begin
         @(posedge clk_i);
      end
      s_ar_valid_i <= 1'b0;
      beats = 0;
      while (beats <= len) begin
         @(posedge clk_i);
         if (s_r_valid_o && s_r_ready_i) begin
            beats++;
         end
      end
   endtask

   // Back-pressure on the IOb port and on R and B
   always @(posedge clk_i) begin
      iob_ready_i <= ($random(seed) % 4) != 0;
      s_r_ready_i <= ($random(seed) % 3) != 0;
      s_b_ready_i <= ($random(seed) % 2) != 0;
   end

   // IOb memory with read data 1 to 3 cycles after acceptance
   always @(posedge clk_i) begin
      logic [31:0] addr;
      addr = iob_req_o.addr;
      iob_rvalid_i <= 1'b0;
      if (!arst_i) begin
         if (rd_wait > 0) begin
            rd_wait = rd_wait - 1;
            if (rd_wait == 0) begin
               iob_rvalid_i <= 1'b1;
               iob_rdata_i  <= rd_word;
            end
         end
         if (iob_valid_o && iob_ready_i) begin
            if (iob_req_o.wstrb != 4'h0) begin
               if (zero_addr.exists(addr)) begin
                  $display("IOb write issued at %h for a beat with all-zero strobes", addr);
                  proto_errs++;
               end
               iob_mem[addr] = merge_bytes(iob_mem.exists(addr) ? iob_mem[addr] :
                                           fill_word(addr), iob_req_o.wdata, iob_req_o.wstrb);
            end else begin
               rd_word = iob_mem.exists(addr) ? iob_mem[addr] : fill_word(addr);
               rd_wait = $unsigned($random(seed)) % 3;
               if (rd_wait == 0) begin
                  iob_rvalid_i <= 1'b1;
                  iob_rdata_i  <= rd_word;
               end
            end
         end
      end
   end

   // B and R checked as they transfer
   always @(posedge clk_i) begin
      r_exp_t beat;
      if (!arst_i && s_b_valid_o && s_b_ready_i) begin
         if (b_exp_q.size() == 0) begin
            $display("B response received with no write burst outstanding");
            proto_errs++;
         end else begin
            if (w_left != 0) begin
               $display("B response arrived with %0d W beats not yet sent", w_left);
               proto_errs++;
            end
            if (s_b_o.id !== b_exp_q[0]) begin
               $display("FAILED s_b_o.id: expected %h, actual %h", b_exp_q[0], s_b_o.id);
               data_errs++;
            end
            if (s_b_o.resp !== 2'b00) begin
               $display("FAILED s_b_o.resp: expected %h, actual %h", 2'b00, s_b_o.resp);
               data_errs++;
            end
            void'(b_exp_q.pop_front());
         end
      end
      if (!arst_i && s_r_valid_o && s_r_ready_i) begin
         if (r_exp_q.size() == 0) begin
            $display("R beat received with no read beat outstanding");
            proto_errs++;
         end else begin
            beat = r_exp_q.pop_front();
            if (s_r_o.data !== beat.data) begin
               $display("FAILED s_r_o.data at %h: expected %h, actual %h",
                        beat.addr, beat.data, s_r_o.data);
               data_errs++;
            end
            if (s_r_o.id !== beat.id) begin
               $display("FAILED s_r_o.id: expected %h, actual %h", beat.id, s_r_o.id);
               data_errs++;
            end
            if (s_r_o.resp !== 2'b00) begin
               $display("FAILED s_r_o.resp: expected %h, actual %h", 2'b00, s_r_o.resp);
               data_errs++;
            end
            if (s_r_o.last !== beat.last) begin
               $display("FAILED s_r_o.last: expected %h, actual %h", beat.last, s_r_o.last);
               data_errs++;
            end
         end
      end
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles == MAX_CYCLES) begin
         $display("Timeout: bursts did not finish within %0d cycles", MAX_CYCLES);
         proto_errs++;
         print_summary();
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      logic [3:0]  id;
      logic [31:0] addr;
      logic [7:0]  len;
      logic [2:0]  size;
      int          k;
      seed         = 32'he9aa;
      data_errs    = 0;
      proto_errs   = 0;
      cycles       = 0;
      w_left       = 0;
      rd_wait      = 0;
      clk_i        = 1'b0;
      arst_i       = 1'b0;
      s_aw_i       = '0;
      s_aw_valid_i = 1'b0;
      s_w_i        = '0;
      s_w_valid_i  = 1'b0;
      s_b_ready_i  = 1'b0;
      s_ar_i       = '0;
      s_ar_valid_i = 1'b0;
      s_r_ready_i  = 1'b0;
      iob_ready_i  = 1'b0;
      iob_rvalid_i = 1'b0;
      iob_rdata_i  = '0;
      #1 arst_i = 1'b1;
      repeat (8) @(posedge clk_i);
      arst_i <= 1'b0;
      @(posedge clk_i);
      // Each write burst is read back on its own
      for (k = 0; k < NUM_PAIRS; k++) begin
         size = $unsigned($random(seed)) % 3;
         len  = $unsigned($random(seed)) % 16;
         addr = 32'h0001_0000 + k * 512 + (($unsigned($random(seed)) % 64) << size);
         pair_addr[k] = addr;
         pair_len[k]  = len;
         pair_size[k] = size;
         id = $random(seed);
         write_burst(id, addr, len, size);
         id = $random(seed);
         read_burst(id, addr, len, size);
      end
      // New writes run alongside reads of earlier regions
      for (k = 0; k < NUM_OVERLAP; k++) begin
         size = $unsigned($random(seed)) % 3;
         len  = $unsigned($random(seed)) % 16;
         addr = 32'h0002_0000 + k * 512 + (($unsigned($random(seed)) % 64) << size);
         ovl_addr[k] = addr;
         ovl_len[k]  = len;
         ovl_size[k] = size;
         id   = $random(seed);
         fork
            write_burst(id, addr, len, size);
            read_burst(id ^ 4'h5, pair_addr[k], pair_len[k], pair_size[k]);
         join
      end
      // Writes made during the overlap are read back last
      for (k = 0; k < NUM_OVERLAP; k++) begin
         id = $random(seed);
         read_burst(id, ovl_addr[k], ovl_len[k], ovl_size[k]);
      end
      repeat (4) @(posedge clk_i);
      if (r_exp_q.size() != 0 || b_exp_q.size() != 0) begin
         $display("Responses still missing at the end of the run");
         proto_errs++;
      end
      print_summary();
      if (data_errs + proto_errs + dut0.assert0.fail_cnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
